// File: flist.f
rtl/ts_pkg.sv
rtl/buf_pkg.sv
rtl/ts_packet_framer.sv
rtl/pkt_buf_arbiter.sv
rtl/ts_apb_regs.sv
rtl/ts_capture_top.sv
bench/ts_capture_asserts.sv
bench/ts_capture_tb.sv

// File: bench/ts_capture_tb.sv
`default_nettype none

module ts_capture_tb
	import ts_pkg::*;
	import buf_pkg::*;
();

	localparam int N_PKTS     = 18;
	localparam int APB_MARGIN = 4000;
	localparam int CYCLES_MAX = (N_PKTS * TS_PKT_BYTES * 2 + APB_MARGIN) * 2;
	localparam int READY_MAX  = 20;

	// Packet kinds sent by the stream driver
	localparam int PK_GOOD  = 0;
	localparam int PK_SHORT = 1;
	localparam int PK_TAG   = 2;
	localparam int PK_SYNC  = 3;

	logic                  ts_clk;
	logic                  S_AXI_ARESETN;
	logic                  ts_valid;
	logic                  ts_sync;
	logic [TS_SYM_W-1:0]   ts_data;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	logic [31:0]           pwdata;
	logic [31:0]           prdata;
	logic                  pready;
	logic                  pslverr;

	logic [31:0]           lcg_state;
	int                    errors;
	int                    checks;
	logic [31:0]           ring_q [$];
	int                    exp_acc;
	int                    exp_drop;
	int                    exp_err;
	int                    exp_tail;
	logic                  m_enable;
	logic                  m_pass_all;
	logic                  m_a_en;
	logic                  m_b_en;
	logic [TS_PID_W-1:0]   m_pid_a;
	logic [TS_PID_W-1:0]   m_pid_b;

	ts_capture_top u_ts_capture_top (
		.ts_clk        (ts_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.ts_valid      (ts_valid),
		.ts_sync       (ts_sync),
		.ts_data       (ts_data),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr)
	);

	always #50 ts_clk = ~ts_clk;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic expect_eq(input string name, input logic [31:0] want, input logic [31:0] got);
		checks++;
		assert (got === want)
		else begin
			errors++;
			$display("mismatch %s: expected %h actual %h", name, want, got);
		end
	endtask

	// ====================================================================
	// APB master
	// ====================================================================
	task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waits;
		@(posedge ts_clk);
		#10;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge ts_clk);
		#10;
		penable = 1'b1;
		waits = 0;
		@(negedge ts_clk);
		while (!pready && (waits < READY_MAX)) begin
			@(negedge ts_clk);
			waits++;
		end
		assert (pready)
		else begin
			errors++;
			$display("APB transfer at address %h never got pready", addr);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge ts_clk);
		#10;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic reg_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic        err;
		apb_xfer(1'b1, addr, data, rdata, err);
		assert (!err)
		else begin
			errors++;
			$display("write to address %h returned an error response", addr);
		end
	endtask

	task automatic reg_expect(input string name, input logic [APB_ADDR_W-1:0] addr,
		input logic [31:0] want);
		logic [31:0] rdata;
		logic        err;
		apb_xfer(1'b0, addr, 32'd0, rdata, err);
		assert (!err)
		else begin
			errors++;
			$display("%s: read of address %h returned an error response", name, addr);
		end
		expect_eq(name, want, rdata);
	endtask

	task automatic expect_slverr(input string name, input logic [APB_ADDR_W-1:0] addr);
		logic [31:0] rdata;
		logic        err;
		apb_xfer(1'b0, addr, 32'd0, rdata, err);
		checks++;
		assert (err)
		else begin
			errors++;
			$display("%s: read of address %h gave no error response", name, addr);
		end
	endtask

	task automatic set_ctrl(input logic enable, input logic pass_all);
		m_enable = enable;
		m_pass_all = pass_all;
		reg_write(REG_CTRL, {30'd0, pass_all, enable});
	endtask

	task automatic set_pids(input logic [TS_PID_W-1:0] a, input logic a_en,
		input logic [TS_PID_W-1:0] b, input logic b_en);
		m_pid_a = a;
		m_a_en = a_en;
		m_pid_b = b;
		m_b_en = b_en;
		reg_write(REG_PID_A, {18'd0, a_en, a});
		reg_write(REG_PID_B, {18'd0, b_en, b});
	endtask

	task automatic check_counts(input string name);
		logic [31:0] status;
		status = (exp_tail << STAT_SLOT_LSB) | (ring_q.size() / TS_PKT_WORDS);
		reg_expect({name, " accepted"}, REG_CNT_ACC, exp_acc);
		reg_expect({name, " dropped"}, REG_CNT_DROP, exp_drop);
		reg_expect({name, " errors"}, REG_CNT_ERR, exp_err);
		reg_expect({name, " status"}, REG_STATUS, status);
	endtask

	// Reads the oldest slot through the window, then releases it
	task automatic drain_oldest(input string name);
		logic [31:0] rdata;
		logic        err;
		for (int n = 0; n < TS_PKT_WORDS; n++) begin
			apb_xfer(1'b0, BUF_WIN_BASE + 12'(4 * n), 32'd0, rdata, err);
			assert (!err)
			else begin
				errors++;
				$display("%s: window read of word %0d returned an error response", name, n);
			end
			expect_eq(name, ring_q[n], rdata);
		end
		reg_write(REG_RELEASE, 32'd0);
		repeat (TS_PKT_WORDS) void'(ring_q.pop_front());
		exp_tail = (exp_tail + 1) % BUF_SLOTS;
	endtask

	// ====================================================================
	// Stream driver with the reference model of the slot ring
	// ====================================================================
	task automatic send_packet(input logic [TS_PID_W-1:0] pid, input int kind);
		ts_word_u    head_word;
		logic [7:0]  pkt [TS_PKT_BYTES];
		logic [31:0] rnd;
		logic [1:0]  tag;
		logic        hit;
		int          len;
		rnd = next_rand();
		head_word = '0;
		head_word.hdr.sync = (kind == PK_SYNC) ? 8'h48 : TS_SYNC_BYTE;
		head_word.hdr.pusi = 1'b1;
		head_word.hdr.pid = pid;
		head_word.hdr.afc = 2'b01;
		head_word.hdr.cc = rnd[3:0];
		for (int i = 0; i < 4; i++)
			pkt[i] = head_word.raw[3 - i];
		for (int i = 4; i < TS_PKT_BYTES; i++) begin
			rnd = next_rand();
			pkt[i] = rnd[23:16];
		end
		hit = m_pass_all || (m_a_en && (pid == m_pid_a)) || (m_b_en && (pid == m_pid_b));
		if (m_enable) begin
			if (kind != PK_GOOD) begin
				exp_err++;
			end else if (hit && (ring_q.size() < BUF_SLOTS * TS_PKT_WORDS)) begin
				exp_acc++;
				for (int i = 0; i < TS_PKT_WORDS; i++)
					ring_q.push_back({pkt[4*i], pkt[4*i+1], pkt[4*i+2], pkt[4*i+3]});
			end else if (hit) begin
				exp_drop++;
			end
		end
		// A short packet is cut off by the sync of the packet after it
		len = (kind == PK_SHORT) ? 100 : TS_PKT_BYTES;
		for (int i = 0; i < len; i++) begin
			@(posedge ts_clk);
			#10;
			tag = ((kind == PK_TAG) && (i == 50)) ? 2'b01 : TS_GOOD_TAG;
			ts_valid = 1'b1;
			ts_sync = (i == 0);
			ts_data = {tag, pkt[i]};
			@(posedge ts_clk);
			#10;
			ts_valid = 1'b0;
			ts_sync = 1'b0;
		end
		repeat (4) @(posedge ts_clk);
	endtask

	initial begin
		logic [31:0]         rnd;
		logic [TS_PID_W-1:0] pid_x;
		logic [TS_PID_W-1:0] pid_y;
		ts_clk = 1'b0;
		S_AXI_ARESETN = 1'b0;
		ts_valid = 1'b0;
		ts_sync = 1'b0;
		ts_data = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		lcg_state = 32'hcf40;
		errors = 0;
		checks = 0;
		exp_acc = 0;
		exp_drop = 0;
		exp_err = 0;
		exp_tail = 0;
		m_enable = 1'b0;
		m_pass_all = 1'b0;
		m_a_en = 1'b0;
		m_b_en = 1'b0;
		m_pid_a = '0;
		m_pid_b = '0;
		repeat (3) @(posedge ts_clk);
		#10;
		S_AXI_ARESETN = 1'b1;

		rnd = next_rand();
		pid_x = rnd[TS_PID_W-1:0];
		pid_y = pid_x ^ 13'h155;

		for (int i = 0; i < 8; i++)
			reg_expect("reset value", 12'(4 * i), 32'd0);

		// PID B holds the other PID but stays disabled
		set_pids(pid_x, 1'b1, pid_y, 1'b0);
		send_packet(pid_x, PK_GOOD);
		check_counts("capture off");
		expect_slverr("empty window", BUF_WIN_BASE);
		expect_slverr("unmapped address", 12'h020);

		set_ctrl(1'b1, 1'b0);
		send_packet(pid_x, PK_GOOD);
		send_packet(pid_y, PK_GOOD);
		send_packet(pid_x, PK_GOOD);
		send_packet(pid_y, PK_GOOD);
		check_counts("pid filter");
		drain_oldest("pid filter data");
		drain_oldest("pid filter data");

		set_ctrl(1'b1, 1'b1);
		rnd = next_rand();
		send_packet(rnd[TS_PID_W-1:0], PK_GOOD);
		rnd = next_rand();
		send_packet(rnd[TS_PID_W-1:0], PK_GOOD);
		check_counts("pass all");
		drain_oldest("pass all data");
		drain_oldest("pass all data");

		set_ctrl(1'b1, 1'b0);
		repeat (5) send_packet(pid_x, PK_GOOD);
		check_counts("ring full");
		drain_oldest("ring full data");
		check_counts("after release");
		fork
			send_packet(pid_x, PK_GOOD);
			begin
				// Two cycles late, the second window read meets a buffer write
				repeat (2) @(posedge ts_clk);
				drain_oldest("window under traffic");
			end
		join
		check_counts("after traffic");
		repeat (3) drain_oldest("ring drain data");

		send_packet(pid_x, PK_SHORT);
		send_packet(pid_y, PK_GOOD);
		send_packet(pid_x, PK_TAG);
		send_packet(pid_x, PK_SYNC);
		check_counts("framing errors");
		send_packet(pid_x, PK_GOOD);
		check_counts("after errors");
		drain_oldest("after errors data");
		check_counts("final");

		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial begin
		#(CYCLES_MAX * 100);
		$display("watchdog expired before the tests finished");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/ts_capture_asserts.sv
`default_nettype none

module ts_capture_asserts (
	input logic ts_clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic wr_en,
	input logic rd_gnt
);

	// An error response only counts in the cycle that ends the transfer
	slverr_with_ready: assert property (@(posedge ts_clk) disable iff (!rst_n)
		pslverr |-> pready)
		else $error("pslverr raised without pready");

	// The capture writer owns the RAM port whenever it writes
	gnt_not_in_write: assert property (@(posedge ts_clk) disable iff (!rst_n)
		!(rd_gnt && wr_en))
		else $error("read grant given in a write cycle");

	ready_in_access: assert property (@(posedge ts_clk) disable iff (!rst_n)
		!(psel && penable) |-> !pready)
		else $error("pready high outside an access phase");

endmodule

bind ts_apb_regs ts_capture_asserts u_apb_asserts (
	.ts_clk  (ts_clk),
	.rst_n   (S_AXI_ARESETN),
	.psel    (psel),
	.penable (penable),
	.pready  (pready),
	.pslverr (pslverr),
	.wr_en   (1'b0),
	.rd_gnt  (rd_gnt)
);

bind pkt_buf_arbiter ts_capture_asserts u_arb_asserts (
	.ts_clk  (ts_clk),
	.rst_n   (1'b1),
	.psel    (1'b0),
	.penable (1'b0),
	.pready  (1'b0),
	.pslverr (1'b0),
	.wr_en   (wr_en),
	.rd_gnt  (rd_gnt)
);

`default_nettype wire

// File: rtl/ts_capture_top.sv
`default_nettype none

module ts_capture_top
	import ts_pkg::*;
	import buf_pkg::*;
(
	input  logic                  ts_clk,
	input  logic                  S_AXI_ARESETN,
	input  logic                  ts_valid,
	input  logic                  ts_sync,
	input  logic [TS_SYM_W-1:0]   ts_data,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [APB_ADDR_W-1:0] paddr,
	input  logic [31:0]           pwdata,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr
);

	logic                  wr_en;
	logic [BUF_ADDR_W-1:0] wr_addr;
	logic [31:0]           wr_data;
	logic                  pkt_done;
	logic [SLOT_W-1:0]     pkt_slot;
	logic                  cnt_drop_inc;
	logic                  cnt_err_inc;
	logic                  cfg_enable;
	logic                  cfg_pass_all;
	logic [TS_PID_W-1:0]   pid_a;
	logic                  pid_a_en;
	logic [TS_PID_W-1:0]   pid_b;
	logic                  pid_b_en;
	logic                  slot_free;
	logic [SLOT_W-1:0]     wr_slot;
	logic                  rd_req;
	logic [BUF_ADDR_W-1:0] rd_addr;
	logic                  rd_gnt;
	logic [31:0]           rd_data;

	ts_packet_framer u_ts_packet_framer (
		.ts_clk        (ts_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.ts_valid      (ts_valid),
		.ts_sync       (ts_sync),
		.ts_data       (ts_data),
		.cfg_enable    (cfg_enable),
		.cfg_pass_all  (cfg_pass_all),
		.pid_a         (pid_a),
		.pid_a_en      (pid_a_en),
		.pid_b         (pid_b),
		.pid_b_en      (pid_b_en),
		.slot_free     (slot_free),
		.wr_slot       (wr_slot),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.pkt_done      (pkt_done),
		.pkt_slot      (pkt_slot),
		.cnt_drop_inc  (cnt_drop_inc),
		.cnt_err_inc   (cnt_err_inc)
	);

	pkt_buf_arbiter u_pkt_buf_arbiter (
		.ts_clk  (ts_clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_req  (rd_req),
		.rd_addr (rd_addr),
		.rd_gnt  (rd_gnt),
		.rd_data (rd_data)
	);

	ts_apb_regs u_ts_apb_regs (
		.ts_clk        (ts_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr),
		.pkt_done      (pkt_done),
		.pkt_slot      (pkt_slot),
		.cnt_drop_inc  (cnt_drop_inc),
		.cnt_err_inc   (cnt_err_inc),
		.cfg_enable    (cfg_enable),
		.cfg_pass_all  (cfg_pass_all),
		.pid_a         (pid_a),
		.pid_a_en      (pid_a_en),
		.pid_b         (pid_b),
		.pid_b_en      (pid_b_en),
		.slot_free     (slot_free),
		.wr_slot       (wr_slot),
		.rd_req        (rd_req),
		.rd_addr       (rd_addr),
		.rd_gnt        (rd_gnt),
		.rd_data       (rd_data)
	);

endmodule

`default_nettype wire

// File: rtl/ts_apb_regs.sv
`default_nettype none

module ts_apb_regs
	import ts_pkg::*;
	import buf_pkg::*;
(
	input  logic                  ts_clk,
	input  logic                  S_AXI_ARESETN,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [APB_ADDR_W-1:0] paddr,
	input  logic [31:0]           pwdata,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr,
	input  logic                  pkt_done,
	input  logic [SLOT_W-1:0]     pkt_slot,
	input  logic                  cnt_drop_inc,
	input  logic                  cnt_err_inc,
	output logic                  cfg_enable,
	output logic                  cfg_pass_all,
	output logic [TS_PID_W-1:0]   pid_a,
	output logic                  pid_a_en,
	output logic [TS_PID_W-1:0]   pid_b,
	output logic                  pid_b_en,
	output logic                  slot_free,
	output logic [SLOT_W-1:0]     wr_slot,
	output logic                  rd_req,
	output logic [BUF_ADDR_W-1:0] rd_addr,
	input  logic                  rd_gnt,
	input  logic [31:0]           rd_data
);

	logic [SLOT_W-1:0] head;
	logic [SLOT_W-1:0] tail;
	logic [SLOT_W:0]   full_cnt;
	logic [31:0]       cnt_acc;
	logic [31:0]       cnt_drop;
	logic [31:0]       cnt_err;
	logic              gnt_q;
	logic              access;
	logic              win_sel;
	logic              win_rd;
	logic              reg_hit;
	logic              reg_wr;
	logic              release_wr;
	logic [31:0]       reg_rdata;

	function automatic logic [31:0] sat_inc(input logic [31:0] cnt, input logic inc);
		if (inc && (cnt != '1))
			return cnt + 32'd1;
		return cnt;
	endfunction

	// ====================================================================
	// APB decode and buffer window
	// ====================================================================
	assign access = psel && penable;
	assign win_sel = (paddr >= BUF_WIN_BASE) && (paddr < BUF_WIN_BASE + 4 * TS_PKT_WORDS) &&
		(paddr[1:0] == 2'b00);
	assign win_rd = access && win_sel && !pwrite && (full_cnt != 0);

	// Data granted last cycle is on rd_data now, which ends the transfer
	assign rd_req = win_rd && !gnt_q;
	assign rd_addr = {tail, paddr[7:2]};
	assign pready = access && (!win_rd || gnt_q);
	assign pslverr = access && ((!reg_hit && !win_sel) ||
		(win_sel && !pwrite && (full_cnt == 0)));
	assign prdata = gnt_q ? rd_data : reg_rdata;

	assign reg_wr = access && pwrite && reg_hit;
	assign release_wr = reg_wr && (paddr == REG_RELEASE) && (full_cnt != 0);
	assign slot_free = full_cnt < BUF_SLOTS;
	assign wr_slot = head;

	always_comb begin
		reg_hit = 1'b1;
		reg_rdata = '0;
		case (paddr)
			REG_CTRL:     reg_rdata = {30'd0, cfg_pass_all, cfg_enable};
			REG_PID_A:    reg_rdata = {18'd0, pid_a_en, pid_a};
			REG_PID_B:    reg_rdata = {18'd0, pid_b_en, pid_b};
			REG_STATUS: begin
				reg_rdata[SLOT_W:0] = full_cnt;
				reg_rdata[STAT_SLOT_LSB +: SLOT_W] = tail;
			end
			REG_RELEASE:  reg_rdata = '0;
			REG_CNT_ACC:  reg_rdata = cnt_acc;
			REG_CNT_DROP: reg_rdata = cnt_drop;
			REG_CNT_ERR:  reg_rdata = cnt_err;
			default:      reg_hit = 1'b0;
		endcase
	end

	// ====================================================================
	// Configuration, slot ring and counters
	// ====================================================================
	always_ff @(posedge ts_clk) begin
		if (!S_AXI_ARESETN) begin
			cfg_enable <= 1'b0;
			cfg_pass_all <= 1'b0;
			pid_a <= '0;
			pid_a_en <= 1'b0;
			pid_b <= '0;
			pid_b_en <= 1'b0;
			head <= '0;
			tail <= '0;
			full_cnt <= '0;
			cnt_acc <= '0;
			cnt_drop <= '0;
			cnt_err <= '0;
			gnt_q <= 1'b0;
		end else begin
			gnt_q <= rd_gnt;
			if (reg_wr && (paddr == REG_CTRL)) begin
				cfg_enable <= pwdata[0];
				cfg_pass_all <= pwdata[1];
			end
			if (reg_wr && (paddr == REG_PID_A)) begin
				pid_a <= pwdata[TS_PID_W-1:0];
				pid_a_en <= pwdata[TS_PID_W];
			end
			if (reg_wr && (paddr == REG_PID_B)) begin
				pid_b <= pwdata[TS_PID_W-1:0];
				pid_b_en <= pwdata[TS_PID_W];
			end
			if (pkt_done)
				head <= pkt_slot + 1'b1;
			if (release_wr)
				tail <= tail + 1'b1;
			case ({pkt_done, release_wr})
				2'b10:   full_cnt <= full_cnt + 1'b1;
				2'b01:   full_cnt <= full_cnt - 1'b1;
				default: full_cnt <= full_cnt;
			endcase
			cnt_acc <= sat_inc(cnt_acc, pkt_done);
			cnt_drop <= sat_inc(cnt_drop, cnt_drop_inc);
			cnt_err <= sat_inc(cnt_err, cnt_err_inc);
		end
	end

endmodule

`default_nettype wire

// File: rtl/pkt_buf_arbiter.sv
`default_nettype none

module pkt_buf_arbiter
	import buf_pkg::*;
(
	input  logic                  ts_clk,
	input  logic                  wr_en,
	input  logic [BUF_ADDR_W-1:0] wr_addr,
	input  logic [31:0]           wr_data,
	input  logic                  rd_req,
	input  logic [BUF_ADDR_W-1:0] rd_addr,
	output logic                  rd_gnt,
	output logic [31:0]           rd_data
);

	logic [31:0]           mem [2**BUF_ADDR_W];
	logic [BUF_ADDR_W-1:0] ram_addr;

	// The capture writer always wins; it cannot be stalled
	assign rd_gnt = rd_req && !wr_en;

	// Single RAM port, steered by the winner of this cycle
	assign ram_addr = wr_en ? wr_addr : rd_addr;

	always_ff @(posedge ts_clk) begin
		if (wr_en)
			mem[ram_addr] <= wr_data;
		else if (rd_gnt)
			rd_data <= mem[ram_addr];
	end

endmodule

`default_nettype wire

// File: rtl/ts_packet_framer.sv
`default_nettype none

module ts_packet_framer
	import ts_pkg::*;
	import buf_pkg::*;
(
	input  logic                  ts_clk,
	input  logic                  S_AXI_ARESETN,
	input  logic                  ts_valid,
	input  logic                  ts_sync,
	input  logic [TS_SYM_W-1:0]   ts_data,
	input  logic                  cfg_enable,
	input  logic                  cfg_pass_all,
	input  logic [TS_PID_W-1:0]   pid_a,
	input  logic                  pid_a_en,
	input  logic [TS_PID_W-1:0]   pid_b,
	input  logic                  pid_b_en,
	input  logic                  slot_free,
	input  logic [SLOT_W-1:0]     wr_slot,
	output logic                  wr_en,
	output logic [BUF_ADDR_W-1:0] wr_addr,
	output logic [31:0]           wr_data,
	output logic                  pkt_done,
	output logic [SLOT_W-1:0]     pkt_slot,
	output logic                  cnt_drop_inc,
	output logic                  cnt_err_inc
);

	logic [7:0] byte_cnt;
	logic       in_pkt;
	logic       pkt_err;
	logic       pkt_acc;
	logic       wr_last;
	ts_word_u   word_q;
	ts_word_u   word_nxt;
	logic [7:0] pos;
	logic       start;
	logic       live;
	logic       misplaced;
	logic       cur_err;
	logic       cur_acc;
	logic       tag_bad;
	logic       hdr_done;
	logic       sync_bad;
	logic       pid_hit;
	logic       hdr_ok;
	logic       acc_now;
	logic       drop_now;
	logic       err_now;
	logic       write_now;

	// ====================================================================
	// Byte position and header decode
	// ====================================================================
	always_comb begin
		word_nxt.raw = {word_q.raw[2:0], ts_data[7:0]};
		start = ts_valid && ts_sync && cfg_enable;
		misplaced = ts_valid && ts_sync && in_pkt;
		// A sync pulse never continues the packet in progress
		live = ts_valid && (start || (in_pkt && !ts_sync));
		pos = start ? 8'd0 : byte_cnt;
		cur_err = start ? 1'b0 : pkt_err;
		cur_acc = start ? 1'b0 : pkt_acc;
		tag_bad = ts_data[TS_SYM_W-1:8] != TS_GOOD_TAG;
		hdr_done = live && (pos == 8'd3);
		sync_bad = hdr_done && (word_nxt.hdr.sync != TS_SYNC_BYTE);
		pid_hit = cfg_pass_all ||
			(pid_a_en && (word_nxt.hdr.pid == pid_a)) ||
			(pid_b_en && (word_nxt.hdr.pid == pid_b));
		hdr_ok = hdr_done && !tag_bad && !sync_bad && !cur_err && pid_hit;
		acc_now = hdr_ok && slot_free;
		drop_now = hdr_ok && !slot_free;
		err_now = (live && !cur_err && (tag_bad || sync_bad)) || (misplaced && !pkt_err);
		write_now = live && (pos[1:0] == 2'd3) && !tag_bad && (acc_now || cur_acc);
	end

	always_ff @(posedge ts_clk) begin
		if (!S_AXI_ARESETN) begin
			byte_cnt <= '0;
			in_pkt <= 1'b0;
			pkt_err <= 1'b0;
			pkt_acc <= 1'b0;
			wr_en <= 1'b0;
			wr_last <= 1'b0;
			pkt_done <= 1'b0;
			cnt_drop_inc <= 1'b0;
			cnt_err_inc <= 1'b0;
		end else begin
			wr_en <= write_now;
			wr_last <= write_now && (pos == TS_PKT_BYTES - 1);
			pkt_done <= wr_en && wr_last;
			cnt_drop_inc <= drop_now;
			cnt_err_inc <= err_now;
			if (live) begin
				byte_cnt <= pos + 8'd1;
				in_pkt <= pos != TS_PKT_BYTES - 1;
				pkt_err <= cur_err || tag_bad || sync_bad;
				pkt_acc <= (cur_acc || acc_now) && !tag_bad;
			end else if (misplaced) begin
				in_pkt <= 1'b0;
			end
		end
	end

	// Word index is the byte position over four
	always_ff @(posedge ts_clk) begin
		if (live)
			word_q <= word_nxt;
		if (write_now) begin
			wr_addr <= {wr_slot, pos[7:2]};
			wr_data <= word_nxt.raw;
		end
		if (wr_en)
			pkt_slot <= wr_addr[BUF_ADDR_W-1 -: SLOT_W];
	end

endmodule

`default_nettype wire

// File: rtl/buf_pkg.sv
`default_nettype none

package buf_pkg;

	localparam int BUF_SLOTS  = 4;
	localparam int SLOT_W     = 2;
	localparam int BUF_ADDR_W = 8;
	localparam int APB_ADDR_W = 12;

	// Oldest slot index sits at this bit of REG_STATUS, the full count at bit 0
	localparam int STAT_SLOT_LSB = 8;

	// ====================================================================
	// APB register map
	// ====================================================================
	localparam logic [APB_ADDR_W-1:0] REG_CTRL     = 12'h000;
	localparam logic [APB_ADDR_W-1:0] REG_PID_A    = 12'h004;
	localparam logic [APB_ADDR_W-1:0] REG_PID_B    = 12'h008;
	localparam logic [APB_ADDR_W-1:0] REG_STATUS   = 12'h00C;
	localparam logic [APB_ADDR_W-1:0] REG_RELEASE  = 12'h010;
	localparam logic [APB_ADDR_W-1:0] REG_CNT_ACC  = 12'h014;
	localparam logic [APB_ADDR_W-1:0] REG_CNT_DROP = 12'h018;
	localparam logic [APB_ADDR_W-1:0] REG_CNT_ERR  = 12'h01C;
	localparam logic [APB_ADDR_W-1:0] BUF_WIN_BASE = 12'h400;

endpackage

`default_nettype wire

// File: rtl/ts_pkg.sv
`default_nettype none

package ts_pkg;

	localparam int TS_PKT_BYTES = 188;
	localparam int TS_PKT_WORDS = 47;
	localparam int TS_SYM_W     = 10;
	localparam int TS_PID_W     = 13;

	localparam logic [7:0] TS_SYNC_BYTE = 8'h47;
	localparam logic [1:0] TS_GOOD_TAG  = 2'b11;

	// ====================================================================
	// One buffer word, seen either as four stream bytes or as the header
	// ====================================================================

	// The first byte received sits in raw[3]
	typedef union packed {
		logic [3:0][7:0] raw;
		struct packed {
			logic [7:0]          sync;
			logic                tei;
			logic                pusi;
			logic                prio;
			logic [TS_PID_W-1:0] pid;
			logic [1:0]          scramble;
			logic [1:0]          afc;
			logic [3:0]          cc;
		} hdr;
	} ts_word_u;

endpackage

`default_nettype wire
